// File: src/eth_rx_macros.svh
`ifndef ETH_RX_MACROS_SVH
`define ETH_RX_MACROS_SVH

// Start-of-frame delimiter after the preamble
`define ETH_RX_SFD 8'hD5

// Destination address length in bytes
`define ETH_RX_MAC_ADDR_LEN 6

// CRC-32 residue of a good frame, FCS included, MSB-first order
`define ETH_RX_CRC_RESIDUE 32'hC704DD7B

// Frame buffer address width, 2 KB
`define ETH_RX_BUF_AW 11

`endif

// File: src/eth_rx_pkg.sv
`include "eth_rx_macros.svh"

package eth_rx_pkg;

   // Destination MAC, first received byte in the top bits
   typedef logic [`ETH_RX_MAC_ADDR_LEN*8-1:0] mac_addr_t;

   // Framer states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_DEST,
      ST_DATA,
      // Flag raised, waiting for acknowledge
      ST_HOLD,
      // Waiting for rx_dv low
      ST_DRAIN
   } rx_state_t;

endpackage

// File: src/eth_rx_ifs.sv
`timescale 1ns/1ps

`include "eth_rx_macros.svh"

// Assembled bytes from the MII deserializer
interface eth_byte_if;
   logic       valid;
   logic [7:0] data;
   logic       sof;
   logic       dv;

   modport src (
      output valid, data, sof, dv
   );

   modport sink (
      input valid, data, sof, dv
   );
endinterface

// Buffer write port, also watched by the CRC checker
interface eth_buf_wr_if;
   logic                      wr;
   logic [`ETH_RX_BUF_AW-1:0] addr;
   logic [7:0]                data;
   // Pulse in the cycle before the first write of a frame
   logic                      start;

   modport src (
      output wr, addr, data, start
   );

   modport sink (
      input wr, addr, data, start
   );
endinterface

// File: src/eth_mii_deserializer.sv
`timescale 1ns/1ps

`include "eth_rx_macros.svh"

module eth_mii_deserializer (
   input  logic       rx_clk_i,
   input  logic       arst_i,
   input  logic       rx_dv_i,
   input  logic [3:0] rx_data_i,
   eth_byte_if.src    byte_o
);

   logic       dv_q;
   logic [3:0] nib_q;
   logic [3:0] low_q;
   logic       locked;
   logic       phase;
   logic       first;
   logic [7:0] pair;

   // Current nibble on top of the previous one
   assign pair = {nib_q, low_q};
   assign byte_o.dv = dv_q;

   // MII input registers
   always_ff @(posedge rx_clk_i or posedge arst_i) begin
      if (arst_i) begin
         dv_q  <= 1'b0;
         nib_q <= 4'h0;
         low_q <= 4'h0;
      end else begin
         dv_q  <= rx_dv_i;
         nib_q <= rx_data_i;
         // No stale nibble across idle gaps
         low_q <= dv_q ? nib_q : 4'h0;
      end
   end

   // Delimiter hunt and nibble pairing
   always_ff @(posedge rx_clk_i or posedge arst_i) begin
      if (arst_i) begin
         locked       <= 1'b0;
         phase        <= 1'b0;
         first        <= 1'b0;
         byte_o.valid <= 1'b0;
         byte_o.sof   <= 1'b0;
      end else begin
         byte_o.valid <= 1'b0;
         byte_o.sof   <= 1'b0;
         if (!dv_q) begin
            locked <= 1'b0;
            phase  <= 1'b0;
         end else if (!locked) begin
            if (pair == `ETH_RX_SFD) begin
               locked <= 1'b1;
               phase  <= 1'b0;
               first  <= 1'b1;
            end
         end else begin
            phase <= ~phase;
            if (phase) begin
               byte_o.valid <= 1'b1;
               byte_o.sof   <= first;
               first        <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge rx_clk_i) begin
      if (locked && dv_q && phase) begin
         byte_o.data <= pair;
      end
   end

   // One byte per two nibbles
   a_valid_spacing : assert property (@(posedge rx_clk_i) disable iff (arst_i)
      byte_o.valid |=> !byte_o.valid);

endmodule

// File: src/eth_rx_framer.sv
`timescale 1ns/1ps

`include "eth_rx_macros.svh"

module eth_rx_framer
   import eth_rx_pkg::*;
(
   input  logic                      rx_clk_i,
   input  logic                      arst_i,
   eth_byte_if.sink                  byte_i,
   eth_buf_wr_if.src                 wr_o,
   input  logic                      rcv_ack_i,
   output logic                      data_rcvd_o,
   output logic [`ETH_RX_BUF_AW-1:0] frame_len_o,
   output mac_addr_t                 dest_mac_o
);

   localparam int AW      = `ETH_RX_BUF_AW;
   localparam int MAC_LEN = `ETH_RX_MAC_ADDR_LEN;

   rx_state_t     state;
   logic [AW-1:0] wr_cnt;
   logic [AW-1:0] byte_idx;
   logic          accept;
   logic          hold_dly;

   // Byte position within the frame, restarts on the first byte
   assign byte_idx = (state == ST_IDLE) ? '0 : wr_cnt;

   assign accept = byte_i.valid &&
                   (((state == ST_IDLE) && byte_i.sof) ||
                    (state == ST_DEST) || (state == ST_DATA));

   // CRC preset ahead of the first write
   assign wr_o.start = (state == ST_IDLE) && byte_i.valid && byte_i.sof;

   always_ff @(posedge rx_clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_o.wr <= 1'b0;
      end else begin
         wr_o.wr <= accept;
      end
   end

   always_ff @(posedge rx_clk_i) begin
      if (accept) begin
         wr_o.addr <= byte_idx;
         wr_o.data <= byte_i.data;
      end
   end

   always_ff @(posedge rx_clk_i or posedge arst_i) begin
      if (arst_i) begin
         state       <= ST_IDLE;
         wr_cnt      <= '0;
         hold_dly    <= 1'b0;
         data_rcvd_o <= 1'b0;
         frame_len_o <= '0;
         dest_mac_o  <= '0;
      end else begin
         if (accept) begin
            wr_cnt <= byte_idx + AW'(1);
            if (byte_idx < AW'(MAC_LEN)) begin
               dest_mac_o <= {dest_mac_o[$bits(mac_addr_t)-9:0], byte_i.data};
            end
         end

         case (state)
            ST_IDLE: begin
               if (accept) begin
                  state <= ST_DEST;
               end
            end

            ST_DEST, ST_DATA: begin
               if (!byte_i.dv) begin
                  // Last byte may arrive with dv already low
                  frame_len_o <= byte_idx + AW'(byte_i.valid);
                  hold_dly    <= 1'b0;
                  state       <= ST_HOLD;
               end else if (state == ST_DEST && accept &&
                            byte_idx == AW'(MAC_LEN - 1)) begin
                  state <= ST_DATA;
               end
            end

            ST_HOLD: begin
               if (!data_rcvd_o) begin
                  // Two cycles for the last write and the CRC compare
                  hold_dly <= 1'b1;
                  if (hold_dly) begin
                     data_rcvd_o <= 1'b1;
                  end
               end else if (rcv_ack_i) begin
                  data_rcvd_o <= 1'b0;
                  state       <= ST_DRAIN;
               end
            end

            ST_DRAIN: begin
               if (!byte_i.dv) begin
                  state <= ST_IDLE;
               end
            end

            default: state <= ST_IDLE;
         endcase
      end
   end

   // Address 0 is written only by the first byte of a frame
   a_no_wrap : assert property (@(posedge rx_clk_i) disable iff (arst_i)
      (state == ST_DATA && accept) |=> (wr_o.addr != '0));

   a_flag_hold : assert property (@(posedge rx_clk_i) disable iff (arst_i)
      (data_rcvd_o && !rcv_ack_i) |=> data_rcvd_o);

endmodule

// File: src/eth_rx_crc_check.sv
`timescale 1ns/1ps

`include "eth_rx_macros.svh"

module eth_rx_crc_check (
   input  logic       rx_clk_i,
   input  logic       arst_i,
   eth_buf_wr_if.sink wr_i,
   output logic       crc_err_o
);

   logic [31:0] crc_q;
   logic [31:0] crc_next;
   logic [31:0] crc_rev;

   // Reflected CRC-32, one byte LSB first
   function automatic logic [31:0] crc32_byte(input logic [31:0] crc,
                                              input logic [7:0]  data);
      logic [31:0] c;
      c = crc ^ {24'h0, data};
      for (int i = 0; i < 8; i++) begin
         c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
      end
      return c;
   endfunction

   assign crc_next = crc32_byte(crc_q, wr_i.data);

   // Residue constant is MSB first
   assign crc_rev = {<<{crc_next}};

   always_ff @(posedge rx_clk_i or posedge arst_i) begin
      if (arst_i) begin
         crc_q     <= '1;
         crc_err_o <= 1'b0;
      end else if (wr_i.start) begin
         crc_q     <= '1;
         crc_err_o <= 1'b0;
      end else if (wr_i.wr) begin
         crc_q     <= crc_next;
         crc_err_o <= (crc_rev != `ETH_RX_CRC_RESIDUE);
      end
   end

endmodule

// File: src/eth_rx_frame_buffer.sv
`timescale 1ns/1ps

`include "eth_rx_macros.svh"

module eth_rx_frame_buffer (
   input  logic                      rx_clk_i,
   eth_buf_wr_if.sink                wr_i,
   input  logic [`ETH_RX_BUF_AW-1:0] rd_addr_i,
   output logic [7:0]                rd_data_o
);

   localparam int DEPTH = 1 << `ETH_RX_BUF_AW;

   logic [7:0] mem [DEPTH];

   always_ff @(posedge rx_clk_i) begin
      if (wr_i.wr) begin
         mem[wr_i.addr] <= wr_i.data;
      end
   end

   // Registered read, data one cycle after the address
   always_ff @(posedge rx_clk_i) begin
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

// File: src/eth_rx_top.sv
`timescale 1ns/1ps

`include "eth_rx_macros.svh"

module eth_rx_top
   import eth_rx_pkg::*;
(
   input  logic                      rx_clk_i,
   input  logic                      arst_i,

   // MII receive
   input  logic                      rx_dv_i,
   input  logic [3:0]                rx_data_i,

   // Host status
   input  logic                      rcv_ack_i,
   output logic                      data_rcvd_o,
   output logic                      crc_err_o,
   output logic [`ETH_RX_BUF_AW-1:0] frame_len_o,
   output mac_addr_t                 dest_mac_o,

   // Host read port
   input  logic [`ETH_RX_BUF_AW-1:0] rd_addr_i,
   output logic [7:0]                rd_data_o
);

   eth_byte_if   byte_bus ();
   eth_buf_wr_if wr_bus ();

   eth_mii_deserializer u_deser (
      .rx_clk_i (rx_clk_i),
      .arst_i   (arst_i),
      .rx_dv_i  (rx_dv_i),
      .rx_data_i(rx_data_i),
      .byte_o   (byte_bus.src)
   );

   eth_rx_framer u_framer (
      .rx_clk_i   (rx_clk_i),
      .arst_i     (arst_i),
      .byte_i     (byte_bus.sink),
      .wr_o       (wr_bus.src),
      .rcv_ack_i  (rcv_ack_i),
      .data_rcvd_o(data_rcvd_o),
      .frame_len_o(frame_len_o),
      .dest_mac_o (dest_mac_o)
   );

   eth_rx_crc_check u_crc (
      .rx_clk_i (rx_clk_i),
      .arst_i   (arst_i),
      .wr_i     (wr_bus.sink),
      .crc_err_o(crc_err_o)
   );

   eth_rx_frame_buffer u_buf (
      .rx_clk_i (rx_clk_i),
      .wr_i     (wr_bus.sink),
      .rd_addr_i(rd_addr_i),
      .rd_data_o(rd_data_o)
   );

endmodule

// File: bench/eth_rx_tb.sv
`timescale 1ns/1ps

`include "eth_rx_macros.svh"

module eth_rx_tb
   import eth_rx_pkg::*;
();

   localparam int  AW        = `ETH_RX_BUF_AW;
   localparam int  MAC_LEN   = `ETH_RX_MAC_ADDR_LEN;
   localparam time DRIVE_DLY = 2ns;
   // Five frames of up to 58 MII bytes at about 130 cycles each, plus readback and waits
   localparam int  MAX_CYCLES = 3000;

   logic          rx_clk;
   logic          arst;
   logic          rx_dv;
   logic [3:0]    rx_data;
   logic          rcv_ack;
   logic          data_rcvd;
   logic          crc_err;
   logic [AW-1:0] frame_len;
   mac_addr_t     dest_mac;
   logic [AW-1:0] rd_addr;
   logic [7:0]    rd_data;

   logic [7:0] tx_buf [64];
   int         tx_len;
   logic [7:0] exp_buf [64];
   int         exp_len;
   integer     seed;
   int         cycle_cnt;
   logic       quiet_window;

   eth_rx_top u_dut (
      .rx_clk_i   (rx_clk),
      .arst_i     (arst),
      .rx_dv_i    (rx_dv),
      .rx_data_i  (rx_data),
      .rcv_ack_i  (rcv_ack),
      .data_rcvd_o(data_rcvd),
      .crc_err_o  (crc_err),
      .frame_len_o(frame_len),
      .dest_mac_o (dest_mac),
      .rd_addr_i  (rd_addr),
      .rd_data_o  (rd_data)
   );

   initial begin
      rx_clk = 1'b0;
      forever #20ns rx_clk = ~rx_clk;
   end

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic expect_equal(input string what, input logic [47:0] got,
                               input logic [47:0] exp);
      assert (got === exp) else
         abort_run($sformatf("error at %0t: %s is %0h, expected %0h", $time, what, got, exp));
   endtask

   task automatic next_cycle();
      @(posedge rx_clk);
      #DRIVE_DLY;
   endtask

   task automatic drive_nibble(input logic dv, input logic [3:0] nib);
      rx_dv   = dv;
      rx_data = nib;
      next_cycle();
   endtask

   // Low nibble goes out first
   task automatic send_byte(input logic dv, input logic [7:0] b);
      drive_nibble(dv, b[3:0]);
      drive_nibble(dv, b[7:4]);
   endtask

   task automatic go_idle(input int n);
      rx_dv   = 1'b0;
      rx_data = 4'h0;
      repeat (n) next_cycle();
   endtask

   // Ethernet CRC-32, reflected, bits taken LSB first
   task automatic compute_fcs(input int n, output logic [31:0] fcs);
      logic [31:0] crc;
      logic        fb;
      crc = 32'hFFFF_FFFF;
      for (int i = 0; i < n; i++) begin
         for (int b = 0; b < 8; b++) begin
            fb  = crc[0] ^ tx_buf[i][b];
            crc = crc >> 1;
            if (fb) begin
               crc = crc ^ 32'hEDB8_8320;
            end
         end
      end
      fcs = ~crc;
   endtask

   task automatic build_frame(input logic bad_fcs);
      int          n_body;
      logic [31:0] fcs;
      n_body = MAC_LEN + 20 + int'($unsigned($random(seed)) % 21);
      for (int i = 0; i < n_body; i++) begin
         tx_buf[i] = 8'($random(seed));
      end
      compute_fcs(n_body, fcs);
      if (bad_fcs) begin
         fcs[13] = ~fcs[13];
      end
      // FCS least significant byte first
      for (int k = 0; k < 4; k++) begin
         tx_buf[n_body + k] = fcs[8*k +: 8];
      end
      tx_len = n_body + 4;
   endtask

   task automatic send_frame();
      repeat (7) send_byte(1'b1, 8'h55);
      send_byte(1'b1, `ETH_RX_SFD);
      for (int i = 0; i < tx_len; i++) begin
         send_byte(1'b1, tx_buf[i]);
      end
      go_idle(2);
   endtask

   task automatic keep_expected();
      exp_buf = tx_buf;
      exp_len = tx_len;
   endtask

   task automatic wait_for_flag();
      while (data_rcvd !== 1'b1) begin
         next_cycle();
      end
   endtask

   task automatic check_buffer();
      for (int a = 0; a < exp_len; a++) begin
         rd_addr = a[AW-1:0];
         next_cycle();
         expect_equal($sformatf("rd_data_o at %0d", a), 48'(rd_data), 48'(exp_buf[a]));
      end
   endtask

   task automatic check_received(input logic exp_err);
      mac_addr_t exp_mac;
      // First destination byte ends up on top
      for (int i = 0; i < MAC_LEN; i++) begin
         exp_mac[8*(MAC_LEN-1-i) +: 8] = exp_buf[i];
      end
      expect_equal("data_rcvd_o", 48'(data_rcvd), 48'(1'b1));
      expect_equal("crc_err_o", 48'(crc_err), 48'(exp_err));
      expect_equal("frame_len_o", 48'(frame_len), 48'(exp_len));
      expect_equal("dest_mac_o", dest_mac, exp_mac);
      check_buffer();
   endtask

   task automatic acknowledge();
      rcv_ack = 1'b1;
      next_cycle();
      rcv_ack = 1'b0;
      expect_equal("data_rcvd_o after acknowledge", 48'(data_rcvd), 48'(1'b0));
   endtask

   a_flag_until_ack : assert property (@(posedge rx_clk) disable iff (arst)
      (data_rcvd && !rcv_ack) |=> data_rcvd)
      else abort_run($sformatf("error at %0t: data_rcvd_o fell without acknowledge", $time));

   // Status frozen while a frame waits for the host
   a_held_status : assert property (@(posedge rx_clk) disable iff (arst)
      data_rcvd |=> ($stable(frame_len) && $stable(dest_mac) && $stable(crc_err)))
      else abort_run($sformatf("error at %0t: status changed while frame held", $time));

   a_no_false_frame : assert property (@(posedge rx_clk) disable iff (arst)
      quiet_window |-> !data_rcvd)
      else abort_run($sformatf("error at %0t: data_rcvd_o rose without a delimiter", $time));

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge rx_clk);
         cycle_cnt++;
      end
      abort_run($sformatf("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES));
   end

   initial begin
      seed         = 32'h31e0;
      arst         = 1'b1;
      rx_dv        = 1'b0;
      rx_data      = 4'h0;
      rcv_ack      = 1'b0;
      rd_addr      = '0;
      quiet_window = 1'b0;
      tx_len       = 0;
      exp_len      = 0;
      repeat (16) @(posedge rx_clk);
      #DRIVE_DLY;
      arst = 1'b0;
      next_cycle();

      expect_equal("data_rcvd_o after reset", 48'(data_rcvd), 48'(1'b0));
      expect_equal("crc_err_o after reset", 48'(crc_err), 48'(1'b0));
      expect_equal("frame_len_o after reset", 48'(frame_len), 48'(0));
      expect_equal("dest_mac_o after reset", dest_mac, 48'(0));

      // Preamble only, then a delimiter with rx_dv low
      quiet_window = 1'b1;
      repeat (8) send_byte(1'b1, 8'h55);
      go_idle(4);
      repeat (7) send_byte(1'b1, 8'h55);
      send_byte(1'b0, `ETH_RX_SFD);
      repeat (4) send_byte(1'b1, 8'h55);
      go_idle(20);
      quiet_window = 1'b0;

      build_frame(1'b0);
      keep_expected();
      send_frame();
      wait_for_flag();
      check_received(1'b0);
      acknowledge();

      build_frame(1'b1);
      keep_expected();
      send_frame();
      wait_for_flag();
      check_received(1'b1);
      acknowledge();

      // Second frame arrives while the first is still held
      build_frame(1'b0);
      keep_expected();
      send_frame();
      wait_for_flag();
      check_received(1'b0);
      build_frame(1'b0);
      send_frame();
      go_idle(4);
      check_received(1'b0);
      acknowledge();

      build_frame(1'b0);
      keep_expected();
      send_frame();
      wait_for_flag();
      check_received(1'b0);
      acknowledge();

      go_idle(4);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// File: flist.f
+incdir+src
src/eth_rx_pkg.sv
src/eth_rx_ifs.sv
src/eth_mii_deserializer.sv
src/eth_rx_framer.sv
src/eth_rx_crc_check.sv
src/eth_rx_frame_buffer.sv
src/eth_rx_top.sv
bench/eth_rx_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := eth_rx_tb
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --assert --timing -j 0
LINT_FLAGS := --lint-only --assert --timing
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
